//--- hw/fir_params.svh
/* FIR filter constants
   Tap count, data widths, lane count, multiply depth and output scaling */

`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// Filter length and tap address width
`define FIR_TAPS        64
`define FIR_TAP_AW      6

// Data path widths
`define FIR_SAMPLE_W    16      // Signed Q1.15 samples
`define FIR_COEF_W      16      // Signed Q1.15 coefficients
`define FIR_PROD_W      32      // Full product, no rounding
`define FIR_ACC_W       38      // Product plus 6 bits growth for 64 taps

// Interleaved partial sums in the accumulator
`define FIR_LANES       5

// Registered stages in the multiplier
`define FIR_MUL_STAGES  2

// Sum to output scaling, back to Q1.15
`define FIR_OUT_SHIFT   15

`endif

//--- hw/fir_num_pkg.sv
/* FIR numeric types
   Signed vectors for the data path and the tap address */

`default_nettype none

`include "fir_params.svh"

package fir_num_pkg;

	// Input sample and narrowed output
	typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;

	// Filter coefficient
	typedef logic signed [`FIR_COEF_W-1:0] coef_t;

	// Exact sample x coefficient
	typedef logic signed [`FIR_PROD_W-1:0] product_t;

	// Partial and final sums, wide enough for all taps
	typedef logic signed [`FIR_ACC_W-1:0] acc_t;

	// Index into either 64-entry memory
	typedef logic [`FIR_TAP_AW-1:0] tap_addr_t;

endpackage

`default_nettype wire

//--- hw/fir_ctrl_pkg.sv
/* FIR control types
   Sequencer states and the beats passed between the pipeline stages */

`default_nettype none

package fir_ctrl_pkg;

	// Sequencer FSM
	// LOAD is the only state that takes coefficient writes
	typedef enum logic [1:0] {
		SEQ_LOAD  = 2'd0,  // After reset, coefficient window open
		SEQ_IDLE  = 2'd1,  // Waiting for the next sample
		SEQ_ISSUE = 2'd2   // Streaming tap pairs, one per cycle
	} seq_state_t;

	// Sequencer to multiplier
	// One sample and coefficient pair per cycle
	typedef struct packed {
		logic                 valid;   // Beat carries a tap
		logic                 last;    // Final tap of the block
		fir_num_pkg::sample_t sample;  // Delayed input sample
		fir_num_pkg::coef_t   coef;    // Matching coefficient
	} tap_beat_t;

	// Multiplier to accumulator
	typedef struct packed {
		logic                  valid;    // Beat carries a product
		logic                  last;     // Final product of the block
		fir_num_pkg::product_t product;  // Exact signed product
	} prod_beat_t;

endpackage

`default_nettype wire

//--- hw/fir_tap_sequencer.sv
/* FIR tap sequencer
   Holds coefficient and sample memories, accepts samples and issues
   one registered tap pair per cycle for each accepted sample */

`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_tap_sequencer (
	input  logic                    alu_clk,
	input  logic                    clk_fast,   // Async reset, active low
	input  fir_num_pkg::sample_t    din,
	input  logic                    din_valid,
	input  fir_num_pkg::coef_t      cin,
	input  fir_num_pkg::tap_addr_t  caddr,
	input  logic                    cload,
	output fir_ctrl_pkg::tap_beat_t tap_beat
);

	localparam fir_num_pkg::tap_addr_t TAP_LAST = fir_num_pkg::tap_addr_t'(`FIR_TAPS - 1);

	fir_ctrl_pkg::seq_state_t state_q;

	// Flop arrays, both cleared by reset
	fir_num_pkg::coef_t   cmem [`FIR_TAPS];
	fir_num_pkg::sample_t smem [`FIR_TAPS];

	fir_num_pkg::tap_addr_t wr_ptr_q;   // Slot of the newest sample
	fir_num_pkg::tap_addr_t tap_cnt_q;  // Tap being issued
	fir_num_pkg::tap_addr_t rd_addr;

	logic accept;
	logic coef_wr;
	logic issuing;
	logic tap_last;

	// Samples only land outside ISSUE, otherwise dropped
	assign accept  = din_valid && (state_q != fir_ctrl_pkg::SEQ_ISSUE);

	// Coefficient window closes with the first sample
	assign coef_wr = cload && (state_q == fir_ctrl_pkg::SEQ_LOAD);

	assign issuing  = (state_q == fir_ctrl_pkg::SEQ_ISSUE);
	assign tap_last = issuing && (tap_cnt_q == TAP_LAST);

	// Walk back from the newest sample, wraps mod 64
	assign rd_addr = wr_ptr_q - tap_cnt_q;

	// Memory writes
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				cmem[i] <= '0;
				smem[i] <= '0;  // Empty history reads as zero
			end
		end else begin
			if (coef_wr) begin
				cmem[caddr] <= cin;
			end
			if (accept) begin
				smem[wr_ptr_q] <= din;  // Newest sample, read back as tap 0
			end
		end
	end

	// Sequencer FSM
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			state_q   <= fir_ctrl_pkg::SEQ_LOAD;
			wr_ptr_q  <= '0;
			tap_cnt_q <= '0;
		end else begin
			case (state_q)
				fir_ctrl_pkg::SEQ_LOAD,
				fir_ctrl_pkg::SEQ_IDLE: begin
					if (accept) begin
						state_q   <= fir_ctrl_pkg::SEQ_ISSUE;
						tap_cnt_q <= '0;
					end
				end
				fir_ctrl_pkg::SEQ_ISSUE: begin
					if (tap_last) begin
						// Block done, next sample goes to the following slot
						state_q   <= fir_ctrl_pkg::SEQ_IDLE;
						wr_ptr_q  <= wr_ptr_q + 1'b1;
						tap_cnt_q <= '0;
					end else begin
						tap_cnt_q <= tap_cnt_q + 1'b1;
					end
				end
				default: begin
					state_q <= fir_ctrl_pkg::SEQ_IDLE;  // Unused code
				end
			endcase
		end
	end

	// Registered tap beat
	// Leaves one cycle after the tap is issued
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			tap_beat <= '0;
		end else begin
			tap_beat.valid  <= issuing;
			tap_beat.last   <= tap_last;   // Marks tap 63
			tap_beat.sample <= smem[rd_addr];
			tap_beat.coef   <= cmem[tap_cnt_q];
		end
	end

endmodule

`default_nettype wire

//--- hw/fir_mul_pipe.sv
/* FIR multiply pipeline
   Signed sample x coefficient product over a fixed number of register stages */

`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_mul_pipe (
	input  logic                     alu_clk,
	input  logic                     clk_fast,   // Async reset, active low
	input  fir_ctrl_pkg::tap_beat_t  tap_beat,
	output fir_ctrl_pkg::prod_beat_t prod_beat
);

	localparam int STAGES = `FIR_MUL_STAGES;

	// Stage registers, index 0 right after the multiplier
	logic                  vld_q  [STAGES];
	logic                  last_q [STAGES];
	fir_num_pkg::product_t prod_q [STAGES];

	fir_num_pkg::product_t mul;

	// Full width signed multiply, exact
	assign mul = fir_num_pkg::product_t'($signed(tap_beat.sample)) *
	             fir_num_pkg::product_t'($signed(tap_beat.coef));

	// Valid and last ride along with the product
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			for (int s = 0; s < STAGES; s++) begin
				vld_q[s]  <= 1'b0;
				last_q[s] <= 1'b0;
			end
		end else begin
			vld_q[0]  <= tap_beat.valid;
			last_q[0] <= tap_beat.last;
			for (int s = 1; s < STAGES; s++) begin
				vld_q[s]  <= vld_q[s-1];
				last_q[s] <= last_q[s-1];
			end
		end
	end

	// Product payload
	always_ff @(posedge alu_clk) begin
		prod_q[0] <= mul;
		for (int s = 1; s < STAGES; s++) begin
			prod_q[s] <= prod_q[s-1];
		end
	end

	always_comb begin
		prod_beat.valid   = vld_q[STAGES-1];
		prod_beat.last    = last_q[STAGES-1];
		prod_beat.product = prod_q[STAGES-1];
	end

endmodule

`default_nettype wire

//--- hw/fir_lane_accumulator.sv
/* FIR lane accumulator
   Sums products into interleaved lanes, folds the lanes into one result,
   then scales and saturates it for the narrow output */

`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_lane_accumulator (
	input  logic                     alu_clk,
	input  logic                     clk_fast,   // Async reset, active low
	input  fir_ctrl_pkg::prod_beat_t prod_beat,
	output fir_num_pkg::sample_t     dout,
	output fir_num_pkg::acc_t        dout_raw,
	output logic                     dout_valid
);

	localparam int LANES  = `FIR_LANES;
	localparam int LANE_W = $clog2(LANES);
	localparam int EXT_W  = `FIR_ACC_W - `FIR_PROD_W;
	localparam logic [LANE_W-1:0] LANE_LAST = LANE_W'(LANES - 1);

	// Output range of sample_t, in sum width
	localparam fir_num_pkg::acc_t SAT_MAX = fir_num_pkg::acc_t'((2 ** (`FIR_SAMPLE_W - 1)) - 1);
	localparam fir_num_pkg::acc_t SAT_MIN = fir_num_pkg::acc_t'(-(2 ** (`FIR_SAMPLE_W - 1)));

	fir_num_pkg::acc_t lane_q [LANES];  // Running partial sums
	fir_num_pkg::acc_t lane_d [LANES];
	fir_num_pkg::acc_t comb_q [LANES];  // Snapshot of a finished block
	fir_num_pkg::acc_t comb_sum_q;
	fir_num_pkg::acc_t final_sum;
	fir_num_pkg::acc_t prod_ext;

	logic [LANE_W-1:0] lane_idx_q;  // Product i goes to lane i mod LANES
	logic [LANE_W-1:0] comb_cnt_q;
	logic              block_open_q;
	logic              comb_busy_q;

	// Arithmetic shift, then clamp into sample_t
	function automatic fir_num_pkg::sample_t sat_sample(input fir_num_pkg::acc_t v);
		fir_num_pkg::acc_t s;
		s = v >>> `FIR_OUT_SHIFT;
		if (s > SAT_MAX) begin
			return fir_num_pkg::sample_t'(SAT_MAX);
		end else if (s < SAT_MIN) begin
			return fir_num_pkg::sample_t'(SAT_MIN);
		end
		return fir_num_pkg::sample_t'(s);
	endfunction

	assign prod_ext = {{EXT_W{prod_beat.product[`FIR_PROD_W-1]}}, prod_beat.product};

	// Next lane values, block start begins from zero
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lane_d[i] = block_open_q ? lane_q[i] : '0;
			if (LANE_W'(i) == lane_idx_q) begin
				lane_d[i] = lane_d[i] + prod_ext;
			end
		end
	end

	// Lane accumulation
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			for (int i = 0; i < LANES; i++) begin
				lane_q[i] <= '0;
			end
			lane_idx_q   <= '0;
			block_open_q <= 1'b0;
		end else if (prod_beat.valid) begin
			if (prod_beat.last) begin
				// Sums move to the combine set, lanes free for the next block
				for (int i = 0; i < LANES; i++) begin
					lane_q[i] <= '0;
				end
				lane_idx_q   <= '0;
				block_open_q <= 1'b0;
			end else begin
				lane_q       <= lane_d;
				lane_idx_q   <= (lane_idx_q == LANE_LAST) ? '0 : lane_idx_q + 1'b1;
				block_open_q <= 1'b1;
			end
		end
	end

	// One lane folded in per combine cycle
	assign final_sum = comb_sum_q + comb_q[comb_cnt_q];

	// Combine and output
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			for (int i = 0; i < LANES; i++) begin
				comb_q[i] <= '0;
			end
			comb_sum_q  <= '0;
			comb_cnt_q  <= '0;
			comb_busy_q <= 1'b0;
			dout        <= '0;
			dout_raw    <= '0;
			dout_valid  <= 1'b0;
		end else begin
			dout_valid <= 1'b0;  // Single cycle strobe
			if (prod_beat.valid && prod_beat.last) begin
				comb_q      <= lane_d;  // Includes the last product
				comb_sum_q  <= '0;
				comb_cnt_q  <= '0;
				comb_busy_q <= 1'b1;
			end else if (comb_busy_q) begin
				comb_sum_q <= final_sum;
				if (comb_cnt_q == LANE_LAST) begin
					comb_busy_q <= 1'b0;
					dout_raw    <= final_sum;
					dout        <= sat_sample(final_sum);
					dout_valid  <= 1'b1;
				end else begin
					comb_cnt_q <= comb_cnt_q + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/fir_filter_top.sv
/* FIR filter top
   Tap sequencer feeding the multiply pipe, feeding the lane accumulator */

`timescale 1ns/100ps
`default_nettype none

module fir_filter_top (
	input  logic                   alu_clk,
	input  logic                   clk_fast,    // Async reset, active low
	input  fir_num_pkg::sample_t   din,         // Sample in
	input  logic                   din_valid,   // Sample strobe
	input  fir_num_pkg::coef_t     cin,         // Coefficient in
	input  fir_num_pkg::tap_addr_t caddr,       // Coefficient address
	input  logic                   cload,       // Coefficient write
	output fir_num_pkg::sample_t   dout,        // Scaled, saturated
	output fir_num_pkg::acc_t      dout_raw,    // Exact sum
	output logic                   dout_valid   // One cycle per block
);

	fir_ctrl_pkg::tap_beat_t  tap_beat;   // Sequencer to multiplier
	fir_ctrl_pkg::prod_beat_t prod_beat;  // Multiplier to accumulator

	// Memories and FSM
	fir_tap_sequencer u_fir_tap_sequencer (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.din       (din),
		.din_valid (din_valid),
		.cin       (cin),
		.caddr     (caddr),
		.cload     (cload),
		.tap_beat  (tap_beat)
	);

	// Pipelined multiplier
	fir_mul_pipe u_fir_mul_pipe (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.tap_beat  (tap_beat),
		.prod_beat (prod_beat)
	);

	// Lane sums, combine and output scaling
	fir_lane_accumulator u_fir_lane_accumulator (
		.alu_clk    (alu_clk),
		.clk_fast   (clk_fast),
		.prod_beat  (prod_beat),
		.dout       (dout),
		.dout_raw   (dout_raw),
		.dout_valid (dout_valid)
	);

endmodule

`default_nettype wire

//--- tb/fir_filter_chk.sv
/* FIR filter checker
   Assertions on the output strobe, the output sum and the sequencer issue length */

`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_filter_chk (
	input  logic                     alu_clk,
	input  logic                     clk_fast,
	input  logic                     dout_valid,
	input  fir_num_pkg::acc_t        dout_raw,
	input  fir_ctrl_pkg::seq_state_t seq_state
);

	int   issue_cycles;      // Length of the running ISSUE phase
	int   fail_cnt = 0;      // Failed assertions so far
	logic in_issue;

	assign in_issue = (seq_state == fir_ctrl_pkg::SEQ_ISSUE);

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			issue_cycles <= 0;
		end else if (in_issue) begin
			issue_cycles <= issue_cycles + 1;
		end else begin
			issue_cycles <= 0;  // Restart for the next sample
		end
	end

	// Output strobe is a single cycle pulse
	a_valid_pulse: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		dout_valid |=> !dout_valid)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("dout_valid high on two cycles in a row");
	end

	// ISSUE never outlasts the tap count
	a_issue_max: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		in_issue |-> (issue_cycles < `FIR_TAPS))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("sequencer stayed in SEQ_ISSUE beyond the tap count");
	end

	// And ends exactly on it
	a_issue_len: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		$fell(in_issue) |-> (issue_cycles == `FIR_TAPS))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("SEQ_ISSUE lasted %0d cycles", issue_cycles);
	end

	a_raw_known: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		dout_valid |-> !$isunknown(dout_raw))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("dout_raw has unknown bits while dout_valid is high");
	end

endmodule

// Sits in the top level, sequencer state taken from inside it
bind fir_filter_top fir_filter_chk u_fir_filter_chk (
	.alu_clk    (alu_clk),
	.clk_fast   (clk_fast),
	.dout_valid (dout_valid),
	.dout_raw   (dout_raw),
	.seq_state  (u_fir_tap_sequencer.state_q)
);

`default_nettype wire

//--- tb/fir_filter_tb.sv
/* FIR filter testbench
   Coefficient load, then impulse, random, dropped and full scale samples
   checked against a golden convolution model */

`timescale 1ns/100ps
`default_nettype none

`include "fir_params.svh"

module fir_filter_tb;

	localparam int IMP_END  = 64;             // Impulse and its 63 zeros
	localparam int RND_END  = IMP_END + 20;   // Random, legal spacing
	localparam int DROP_END = RND_END + 6;    // Two rows land in ISSUE
	localparam int POS_END  = DROP_END + 64;  // Positive full scale, whole history
	localparam int ROWS     = POS_END + 64;   // Negative full scale, whole history

	logic                   alu_clk;
	logic                   clk_fast;
	fir_num_pkg::sample_t   din;
	logic                   din_valid;
	fir_num_pkg::coef_t     cin;
	fir_num_pkg::tap_addr_t caddr;
	logic                   cload;
	fir_num_pkg::sample_t   dout;
	fir_num_pkg::acc_t      dout_raw;
	logic                   dout_valid;

	// Stimulus table, expected columns filled by the model
	fir_num_pkg::sample_t row_din      [ROWS];
	int                   row_gap      [ROWS];  // Cycles to the next strobe
	bit                   row_acc      [ROWS];  // Sample will be taken
	fir_num_pkg::acc_t    row_exp_raw  [ROWS];
	fir_num_pkg::sample_t row_exp_dout [ROWS];
	fir_num_pkg::coef_t   coef_tab     [`FIR_TAPS];

	integer seed = 88046;
	int     n_acc;
	int     total_gap;
	int     pulses = 0;
	int     mon_row = 0;     // Next row the monitor expects
	int     cycle_cnt = 0;
	int     mismatch_errs = 0;
	int     other_errs = 0;
	logic   sample_sent = 1'b0;
	logic   table_ready = 1'b0;

	fir_filter_top u_fir_filter_top (
		.alu_clk    (alu_clk),
		.clk_fast   (clk_fast),
		.din        (din),
		.din_valid  (din_valid),
		.cin        (cin),
		.caddr      (caddr),
		.cload      (cload),
		.dout       (dout),
		.dout_raw   (dout_raw),
		.dout_valid (dout_valid)
	);

	initial begin
		alu_clk = 1'b0;
		forever #2 alu_clk = ~alu_clk;  // 4 ns period
	end

	// Back to Q1.15, clamped to the sample range
	function automatic fir_num_pkg::sample_t scale_to_sample(input fir_num_pkg::acc_t sum);
		fir_num_pkg::acc_t q;
		q = sum >>> `FIR_OUT_SHIFT;
		if (q > fir_num_pkg::acc_t'(32767)) begin
			return fir_num_pkg::sample_t'(16'h7fff);
		end
		if (q < fir_num_pkg::acc_t'(-32768)) begin
			return fir_num_pkg::sample_t'(16'h8000);
		end
		return fir_num_pkg::sample_t'(q);
	endfunction

	task automatic build_table();
		int i;
		int k;
		int off;
		int t;
		int last_t;
		fir_num_pkg::sample_t hist [`FIR_TAPS];  // Model history, newest at 0
		fir_num_pkg::acc_t    sum;
		for (k = 0; k < `FIR_TAPS; k++) begin
			if (k % 9 == 4) begin
				coef_tab[k] = fir_num_pkg::coef_t'(-(200 + 11 * k));  // Few negative taps
			end else begin
				coef_tab[k] = fir_num_pkg::coef_t'(600 + 37 * k);
			end
			hist[k] = '0;
		end
		for (i = 0; i < ROWS; i++) begin
			row_gap[i] = `FIR_TAPS + 1;  // Tightest legal spacing
			if (i < IMP_END) begin
				row_din[i] = (i == 0) ? fir_num_pkg::sample_t'(16'h8000) : '0;  // -2^15
			end else if (i < RND_END) begin
				row_din[i] = fir_num_pkg::sample_t'($random(seed));
				row_gap[i] = `FIR_TAPS + 1 + ($random(seed) & 15);
			end else if (i < DROP_END) begin
				off = i - RND_END;
				row_din[i] = fir_num_pkg::sample_t'($random(seed));
				row_gap[i] = (off == 1 || off == 3) ? 12 + 4 * off : 70;  // Next row too early
			end else if (i < POS_END) begin
				row_din[i] = fir_num_pkg::sample_t'(16'h7fff);
			end else begin
				row_din[i] = fir_num_pkg::sample_t'(16'h8000);
			end
		end
		// Golden model, strobe times from the gaps
		t = 0;
		last_t = -(`FIR_TAPS + 1);
		n_acc = 0;
		for (i = 0; i < ROWS; i++) begin
			row_acc[i] = (t - last_t) >= (`FIR_TAPS + 1);
			row_exp_raw[i] = '0;
			row_exp_dout[i] = '0;
			if (row_acc[i]) begin
				for (k = `FIR_TAPS - 1; k > 0; k--) begin
					hist[k] = hist[k-1];
				end
				hist[0] = row_din[i];
				sum = '0;
				for (k = 0; k < `FIR_TAPS; k++) begin
					sum = sum + fir_num_pkg::acc_t'(coef_tab[k]) * fir_num_pkg::acc_t'(hist[k]);
				end
				row_exp_raw[i] = sum;
				row_exp_dout[i] = scale_to_sample(sum);
				last_t = t;
				n_acc++;
			end
			t = t + row_gap[i];
		end
		total_gap = t;
	endtask

	task automatic check_raw(input fir_num_pkg::acc_t got, input fir_num_pkg::acc_t exp,
	                         input int row);
		if (got !== exp) begin
			mismatch_errs++;
			$display("mismatch dout_raw row %0d: got %h expected %h", row, got, exp);
		end
	endtask

	task automatic check_dout(input fir_num_pkg::sample_t got, input fir_num_pkg::sample_t exp,
	                          input int row);
		if (got !== exp) begin
			mismatch_errs++;
			$display("mismatch dout row %0d: got %h expected %h", row, got, exp);
		end
	endtask

	// Output monitor, away from the active edge
	always @(negedge alu_clk) begin
		if (dout_valid) begin
			pulses = pulses + 1;
			if (!sample_sent) begin
				other_errs++;
				$display("dout_valid pulsed before any sample was applied");
			end else begin
				while (mon_row < ROWS && !row_acc[mon_row]) begin
					mon_row++;  // Dropped rows give no output
				end
				if (mon_row >= ROWS) begin
					other_errs++;
					$display("more output pulses than accepted samples");
				end else begin
					check_raw(dout_raw, row_exp_raw[mon_row], mon_row);
					check_dout(dout, row_exp_dout[mon_row], mon_row);
					mon_row++;
				end
			end
		end
	end

	initial begin
		int i;
		int c;
		clk_fast = 1'b0;
		din = '0;
		din_valid = 1'b0;
		cin = '0;
		caddr = '0;
		cload = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge alu_clk);
		clk_fast <= 1'b1;
		// Coefficient window, open until the first sample
		for (i = 0; i < `FIR_TAPS; i++) begin
			@(posedge alu_clk);
			cin   <= coef_tab[i];
			caddr <= fir_num_pkg::tap_addr_t'(i);
			cload <= 1'b1;
		end
		@(posedge alu_clk);
		cload <= 1'b0;
		@(posedge alu_clk);
		for (i = 0; i < ROWS; i++) begin
			din         <= row_din[i];
			din_valid   <= 1'b1;
			sample_sent <= 1'b1;
			// Late write beside the strobe, lands in IDLE or ISSUE and must not stick
			if (i > 0) begin
				cin   <= fir_num_pkg::coef_t'($random(seed));
				caddr <= fir_num_pkg::tap_addr_t'(i);
				cload <= 1'b1;
			end
			@(posedge alu_clk);
			din_valid <= 1'b0;
			cload     <= 1'b0;
			for (c = 1; c < row_gap[i]; c++) begin
				@(posedge alu_clk);
			end
		end
		while (pulses < n_acc) begin
			@(posedge alu_clk);
		end
		repeat (`FIR_TAPS + 16) @(posedge alu_clk);  // Room for a stray pulse
		if (pulses != n_acc) begin
			other_errs++;
			$display("saw %0d output pulses for %0d accepted samples", pulses, n_acc);
		end
		$display("errors: %0d mismatches, %0d other, %0d assertion failures",
		         mismatch_errs, other_errs, u_fir_filter_top.u_fir_filter_chk.fail_cnt);
		if (mismatch_errs + other_errs + u_fir_filter_top.u_fir_filter_chk.fail_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Limit from the table length, reset, coefficient load and margin
	initial begin
		int limit;
		wait (table_ready);
		limit = total_gap + 8 + `FIR_TAPS + 500;
		while (cycle_cnt < limit) begin
			@(posedge alu_clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, outputs still missing", cycle_cnt);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/fir_num_pkg.sv
hw/fir_ctrl_pkg.sv
hw/fir_tap_sequencer.sv
hw/fir_mul_pipe.sv
hw/fir_lane_accumulator.sv
hw/fir_filter_top.sv
tb/fir_filter_chk.sv
tb/fir_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIR filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fir_filter_tb -f flist.f -o fir_sim

# Error limit raised so assertion errors reach the testbench summary
./obj_dir/fir_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a result line, see sim.log"
	exit 1
fi
echo "Simulation passed"
